//--- cpuIsaPkg.sv
// Fixed 32-bit encoding with opcode in the top six bits; no shift, multiply or call fields exist
package cpuIsaPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [15:0] imm_t;

	localparam int regCount = 32;

	// Field MSBs within an instruction word
	localparam int opcodeMsb = 31;
	localparam int rdMsb = 25;
	localparam int rsMsb = 20;
	localparam int rtMsb = 15;

	// Register-register ALU ops must stay one contiguous range
	typedef enum logic [5:0] {
		opNop = 6'h00,
		opAdd = 6'h01,
		opSub = 6'h02,
		opAnd = 6'h03,
		opOr = 6'h04,
		opXor = 6'h05,
		opSlt = 6'h06,
		opAddi = 6'h07,
		opLw = 6'h08,
		opSw = 6'h09,
		opBeq = 6'h0a,
		opBne = 6'h0b,
		opJmp = 6'h0c,
		opHalt = 6'h0d
	} opcode_e;

endpackage

//--- cpuPipePkg.sv
// Pipeline-internal encodings; the core starts fetching at byte address zero
package cpuPipePkg;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOp_e;

	typedef enum logic [1:0] {
		fromReg,
		fromMem,
		fromWb
	} fwdSel_e;

	localparam cpuIsaPkg::word_t resetPc = '0;

endpackage

//--- fetchStage.sv
// One outstanding instruction request; a word that arrives while decode is stalled waits in a one-entry buffer
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic rst,
	output cpuIsaPkg::word_t instrAddr,
	output logic instrValid,
	input logic instrReady,
	input cpuIsaPkg::word_t instrData,
	input logic redirect,
	input cpuIsaPkg::word_t redirectPc,
	input logic hold,
	input logic freeze,
	input logic halted,
	output cpuIsaPkg::word_t fetchInstr,
	output cpuIsaPkg::word_t fetchPc,
	output logic fetchValid
);

	cpuIsaPkg::word_t pc;
	cpuIsaPkg::word_t nextAddr;
	cpuIsaPkg::word_t bufInstr;
	cpuIsaPkg::word_t bufPc;
	logic bufValid;
	logic drop;
	logic busy;
	logic gotWord;
	logic advance;
	logic bufNext;
	logic issue;

	assign busy = instrValid & ~instrReady;
	// Words from before a redirect are thrown away
	assign gotWord = instrValid & instrReady & ~drop & ~redirect;
	assign advance = ~hold & ~freeze;
	assign bufNext = ~advance & (bufValid | gotWord);
	assign issue = ~halted & ~busy & ~bufNext;
	assign nextAddr = redirect ? redirectPc : pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= cpuPipePkg::resetPc;
			instrValid <= 1'b0;
			drop <= 1'b0;
			bufValid <= 1'b0;
			fetchValid <= 1'b0;
		end else begin
			pc <= issue ? nextAddr + 32'd4 : nextAddr;
			instrValid <= issue | busy;
			drop <= busy & (drop | redirect);
			bufValid <= bufNext;
			if (advance) begin
				fetchValid <= ~redirect & (bufValid | gotWord);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			instrAddr <= nextAddr;
		end
		if (advance) begin
			fetchInstr <= bufValid ? bufInstr : instrData;
			fetchPc <= bufValid ? bufPc : instrAddr;
		end else if (gotWord) begin
			bufInstr <= instrData;
			bufPc <= instrAddr;
		end
	end

endmodule

//--- decodeStage.sv
// Register zero reads as zero; SW and branches take their second register from the rd field
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rst,
	input cpuIsaPkg::word_t fetchInstr,
	input cpuIsaPkg::word_t fetchPc,
	input logic fetchValid,
	input logic hold,
	input logic freeze,
	input logic flush,
	input cpuIsaPkg::regAddr_t wbAddr,
	input cpuIsaPkg::word_t wbData,
	input logic wbEn,
	output cpuIsaPkg::word_t srcA, srcB, imm, pc,
	output cpuPipePkg::aluOp_e aluOp,
	output logic useImm, isLoad, isStore, isBranch,
	output logic branchNe, isJump, isHalt, regWrite,
	output cpuIsaPkg::regAddr_t rd, rs, rt,
	output logic decValid
);

	cpuIsaPkg::word_t regs [cpuIsaPkg::regCount];
	cpuIsaPkg::opcode_e opcode;
	cpuIsaPkg::regAddr_t rdField, rsField, rtField, readIdxB;
	cpuIsaPkg::imm_t immField;
	cpuIsaPkg::word_t readA, readB;
	cpuPipePkg::aluOp_e aluOpDec;
	logic rType, loadOp, storeOp, branchOp, bubble;

	assign opcode = cpuIsaPkg::opcode_e'(fetchInstr[cpuIsaPkg::opcodeMsb -: $bits(opcode)]);
	assign rdField = fetchInstr[cpuIsaPkg::rdMsb -: $bits(cpuIsaPkg::regAddr_t)];
	assign rsField = fetchInstr[cpuIsaPkg::rsMsb -: $bits(cpuIsaPkg::regAddr_t)];
	assign rtField = fetchInstr[cpuIsaPkg::rtMsb -: $bits(cpuIsaPkg::regAddr_t)];
	assign immField = fetchInstr[$bits(cpuIsaPkg::imm_t)-1:0];

	assign rType = opcode inside {[cpuIsaPkg::opAdd:cpuIsaPkg::opSlt]};
	assign loadOp = (opcode == cpuIsaPkg::opLw);
	assign storeOp = (opcode == cpuIsaPkg::opSw);
	assign branchOp = (opcode == cpuIsaPkg::opBeq) || (opcode == cpuIsaPkg::opBne);
	assign readIdxB = rType ? rtField : ((storeOp | branchOp) ? rdField : '0);

	// Same-cycle writeback bypasses the array
	assign readA = (rsField == '0) ? '0 :
		((wbEn && wbAddr == rsField) ? wbData : regs[rsField]);
	assign readB = (readIdxB == '0) ? '0 :
		((wbEn && wbAddr == readIdxB) ? wbData : regs[readIdxB]);

	always_ff @(posedge clk) begin
		if (wbEn) begin
			regs[wbAddr] <= wbData;
		end
	end

	always_comb begin
		case (opcode)
			cpuIsaPkg::opAdd: aluOpDec = cpuPipePkg::aluAdd;
			cpuIsaPkg::opSub: aluOpDec = cpuPipePkg::aluSub;
			cpuIsaPkg::opAnd: aluOpDec = cpuPipePkg::aluAnd;
			cpuIsaPkg::opOr: aluOpDec = cpuPipePkg::aluOr;
			cpuIsaPkg::opXor: aluOpDec = cpuPipePkg::aluXor;
			cpuIsaPkg::opSlt: aluOpDec = cpuPipePkg::aluSlt;
			cpuIsaPkg::opAddi,
			cpuIsaPkg::opLw,
			cpuIsaPkg::opSw: aluOpDec = cpuPipePkg::aluAdd;
			default: aluOpDec = cpuPipePkg::aluPassB;
		endcase
	end

	assign bubble = hold | flush | ~fetchValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			decValid <= 1'b0;
			isLoad <= 1'b0;
			isStore <= 1'b0;
			isBranch <= 1'b0;
			branchNe <= 1'b0;
			isJump <= 1'b0;
			isHalt <= 1'b0;
			regWrite <= 1'b0;
		end else if (!freeze) begin
			decValid <= ~bubble;
			isLoad <= ~bubble & loadOp;
			isStore <= ~bubble & storeOp;
			isBranch <= ~bubble & branchOp;
			branchNe <= ~bubble & (opcode == cpuIsaPkg::opBne);
			isJump <= ~bubble & (opcode == cpuIsaPkg::opJmp);
			isHalt <= ~bubble & (opcode == cpuIsaPkg::opHalt);
			regWrite <= ~bubble & (rType | loadOp | opcode == cpuIsaPkg::opAddi);
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			srcA <= readA;
			srcB <= readB;
			imm <= cpuIsaPkg::word_t'($signed(immField));
			pc <= fetchPc;
			aluOp <= aluOpDec;
			useImm <= loadOp | storeOp | (opcode == cpuIsaPkg::opAddi);
			rd <= rdField;
			rs <= rsField;
			rt <= readIdxB;
		end
	end

endmodule

//--- executeStage.sv
// Branches and jumps resolve here; redirect is combinational and only fires when the pipe moves
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rst,
	input cpuIsaPkg::word_t srcA, srcB, imm, pc,
	input cpuPipePkg::aluOp_e aluOp,
	input logic useImm, isLoad, isStore, isBranch,
	input logic branchNe, isJump, isHalt, regWrite,
	input cpuIsaPkg::regAddr_t rd,
	input logic decValid,
	input cpuPipePkg::fwdSel_e fwdA,
	input cpuPipePkg::fwdSel_e fwdB,
	input cpuIsaPkg::word_t wbData,
	input logic freeze,
	output logic redirect,
	output cpuIsaPkg::word_t redirectPc,
	output cpuIsaPkg::word_t exResult,
	output cpuIsaPkg::word_t exStoreData,
	output cpuIsaPkg::regAddr_t exRd,
	output logic exRegWrite, exLoad, exStore, exHalt, exValid
);

	cpuIsaPkg::word_t opA, opB, aluB, aluOut;
	logic taken;

	function automatic cpuIsaPkg::word_t pickOperand(
		input cpuPipePkg::fwdSel_e sel,
		input cpuIsaPkg::word_t regVal,
		input cpuIsaPkg::word_t memVal,
		input cpuIsaPkg::word_t wbVal
	);
		case (sel)
			cpuPipePkg::fromMem: return memVal;
			cpuPipePkg::fromWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, srcA, exResult, wbData);
	assign opB = pickOperand(fwdB, srcB, exResult, wbData);
	assign aluB = useImm ? imm : opB;

	always_comb begin
		case (aluOp)
			cpuPipePkg::aluAdd: aluOut = opA + aluB;
			cpuPipePkg::aluSub: aluOut = opA - aluB;
			cpuPipePkg::aluAnd: aluOut = opA & aluB;
			cpuPipePkg::aluOr: aluOut = opA | aluB;
			cpuPipePkg::aluXor: aluOut = opA ^ aluB;
			cpuPipePkg::aluSlt: aluOut = cpuIsaPkg::word_t'($signed(opA) < $signed(aluB));
			default: aluOut = aluB;
		endcase
	end

	// Target is relative to the next sequential word
	assign taken = isJump | (isBranch & ((opA == opB) ^ branchNe));
	assign redirect = decValid & taken & ~freeze;
	assign redirectPc = pc + 32'd4 + (imm << 2);

	always_ff @(posedge clk) begin
		if (rst) begin
			exValid <= 1'b0;
			exRegWrite <= 1'b0;
			exLoad <= 1'b0;
			exStore <= 1'b0;
			exHalt <= 1'b0;
		end else if (!freeze) begin
			exValid <= decValid;
			exRegWrite <= regWrite;
			exLoad <= isLoad;
			exStore <= isStore;
			exHalt <= isHalt;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			exResult <= aluOut;
			exStoreData <= opB;
			exRd <= rd;
		end
	end

endmodule

//--- memoryStage.sv
// Holds the data request stable until ready; halt is sticky and blocks all later data requests
`timescale 1ns/1ps

module memoryStage (
	input logic clk,
	input logic rst,
	input cpuIsaPkg::word_t exResult,
	input cpuIsaPkg::word_t exStoreData,
	input cpuIsaPkg::regAddr_t exRd,
	input logic exRegWrite, exLoad, exStore, exHalt, exValid,
	output cpuIsaPkg::word_t dataAddr,
	output logic dataWrite,
	output cpuIsaPkg::word_t dataWdata,
	output logic dataValid,
	input logic dataReady,
	input cpuIsaPkg::word_t dataRdata,
	output logic memWait,
	output cpuIsaPkg::regAddr_t wbAddr,
	output cpuIsaPkg::word_t wbData,
	output logic wbEn,
	output logic halt
);

	assign dataAddr = exResult;
	assign dataWrite = exStore;
	assign dataWdata = exStoreData;
	assign dataValid = exValid & (exLoad | exStore) & ~halt;
	assign memWait = dataValid & ~dataReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			wbEn <= 1'b0;
			halt <= 1'b0;
		end else if (!memWait) begin
			wbEn <= exValid & exRegWrite & ~halt;
			halt <= halt | (exValid & exHalt);
		end
	end

	// Load data is taken in the ready cycle
	always_ff @(posedge clk) begin
		if (!memWait) begin
			wbAddr <= exRd;
			wbData <= exLoad ? dataRdata : exResult;
		end
	end

endmodule

//--- hazardUnit.sv
// Load-use check matches all three register fields of the decode word, so some stalls are spurious
`timescale 1ns/1ps

module hazardUnit (
	input cpuIsaPkg::regAddr_t rs,
	input cpuIsaPkg::regAddr_t rt,
	input cpuIsaPkg::word_t fetchInstr,
	input logic fetchValid,
	input logic isLoad,
	input cpuIsaPkg::regAddr_t rd,
	input cpuIsaPkg::regAddr_t exRd,
	input logic exRegWrite,
	input cpuIsaPkg::regAddr_t wbAddr,
	input logic wbEn,
	input logic memWait,
	output logic hold,
	output logic freeze,
	output cpuPipePkg::fwdSel_e fwdA,
	output cpuPipePkg::fwdSel_e fwdB
);

	cpuIsaPkg::regAddr_t decRd, decRs, decRt;

	// Younger result wins
	function automatic cpuPipePkg::fwdSel_e pickSource(
		input cpuIsaPkg::regAddr_t src,
		input cpuIsaPkg::regAddr_t memRd,
		input logic memWe,
		input cpuIsaPkg::regAddr_t wbRd,
		input logic wbWe
	);
		if (src == '0) return cpuPipePkg::fromReg;
		if (memWe && memRd == src) return cpuPipePkg::fromMem;
		if (wbWe && wbRd == src) return cpuPipePkg::fromWb;
		return cpuPipePkg::fromReg;
	endfunction

	assign fwdA = pickSource(rs, exRd, exRegWrite, wbAddr, wbEn);
	assign fwdB = pickSource(rt, exRd, exRegWrite, wbAddr, wbEn);

	assign decRd = fetchInstr[cpuIsaPkg::rdMsb -: $bits(cpuIsaPkg::regAddr_t)];
	assign decRs = fetchInstr[cpuIsaPkg::rsMsb -: $bits(cpuIsaPkg::regAddr_t)];
	assign decRt = fetchInstr[cpuIsaPkg::rtMsb -: $bits(cpuIsaPkg::regAddr_t)];

	assign hold = fetchValid & isLoad & (rd != '0) &
		((rd == decRs) | (rd == decRt) | (rd == decRd));
	assign freeze = memWait;

endmodule

//--- cpuCore.sv
// Five-stage core; both memory ports use valid/ready with any latency, halt stays high until rst
`timescale 1ns/1ps

module cpuCore (
	input logic clk,
	input logic rst,
	output cpuIsaPkg::word_t instrAddr,
	output logic instrValid,
	input logic instrReady,
	input cpuIsaPkg::word_t instrData,
	output cpuIsaPkg::word_t dataAddr,
	output logic dataWrite,
	output cpuIsaPkg::word_t dataWdata,
	output logic dataValid,
	input logic dataReady,
	input cpuIsaPkg::word_t dataRdata,
	output logic halt
);

	// Fetch to decode
	cpuIsaPkg::word_t fetchInstr, fetchPc;
	logic fetchValid;

	// Decode to execute
	cpuIsaPkg::word_t srcA, srcB, imm, pc;
	cpuPipePkg::aluOp_e aluOp;
	logic useImm, isLoad, isStore, isBranch, branchNe, isJump, isHalt, regWrite, decValid;
	cpuIsaPkg::regAddr_t rd, rs, rt;

	// Execute to memory, and the redirect back to fetch
	cpuIsaPkg::word_t exResult, exStoreData, redirectPc;
	cpuIsaPkg::regAddr_t exRd;
	logic exRegWrite, exLoad, exStore, exHalt, exValid, redirect;

	// Writeback
	cpuIsaPkg::regAddr_t wbAddr;
	cpuIsaPkg::word_t wbData;
	logic wbEn, memWait;

	// Hazard control
	logic hold, freeze;
	cpuPipePkg::fwdSel_e fwdA, fwdB;

	fetchStage fetchUnit (.*, .halted(halt));

	decodeStage decodeUnit (.*, .flush(redirect));

	executeStage executeUnit (.*);

	memoryStage memoryUnit (.*);

	hazardUnit hazardCtl (.*);

endmodule

//--- cpuCore_asserts.sv
// Bound into cpuCore; all rules are switched off while rst is high
`timescale 1ns/1ps

module cpuCore_asserts (
	input logic clk,
	input logic rst,
	input cpuIsaPkg::word_t instrAddr,
	input logic instrValid,
	input logic instrReady,
	input cpuIsaPkg::word_t dataAddr,
	input logic dataWrite,
	input cpuIsaPkg::word_t dataWdata,
	input logic dataValid,
	input logic dataReady,
	input logic halt
);

	instrHeld: assert property (@(posedge clk) disable iff (rst)
		instrValid && !instrReady |=> instrValid && $stable(instrAddr))
		else $error("Instruction request dropped or changed before ready");

	// Store data must not move either
	dataHeld: assert property (@(posedge clk) disable iff (rst)
		dataValid && !dataReady |=> dataValid && $stable(dataAddr) && $stable(dataWrite)
			&& $stable(dataWdata))
		else $error("Data request dropped or changed before ready");

	haltSticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
		else $error("halt fell without reset");

endmodule

//--- cpuChecker.sv
// Holds at most 64 expected stores, loaded through addExpected before reset is released
`timescale 1ns/1ps

module cpuChecker (
	input logic clk,
	input logic rst,
	input cpuIsaPkg::word_t instrAddr,
	input logic instrValid,
	input cpuIsaPkg::word_t dataAddr,
	input logic dataWrite,
	input cpuIsaPkg::word_t dataWdata,
	input logic dataValid,
	input logic dataReady,
	input logic halt
);

	cpuIsaPkg::word_t expAddr [64];
	cpuIsaPkg::word_t expData [64];
	int expCount;
	int seenCount;
	int mismatchCount;
	int otherCount;
	logic resetChecked;
	logic fetchChecked;
	logic haltSeen;

	task automatic addExpected(input cpuIsaPkg::word_t addr, input cpuIsaPkg::word_t data);
		expAddr[expCount] = addr;
		expData[expCount] = data;
		expCount++;
	endtask

	task automatic finishReport(output int total);
		if (seenCount < expCount) begin
			$display("Missing stores: only %0d of %0d expected stores reached the data port",
				seenCount, expCount);
			otherCount++;
		end
		total = mismatchCount + otherCount;
		$display("Checks done: %0d mismatches, %0d other errors, %0d of %0d stores seen",
			mismatchCount, otherCount, seenCount, expCount);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			resetChecked <= 1'b0;
			fetchChecked <= 1'b0;
			haltSeen <= 1'b0;
		end else begin
			if (!resetChecked) begin
				resetChecked <= 1'b1;
				if (instrValid || dataValid || halt) begin
					$display("MISMATCH at %0t: after reset instrValid=%b dataValid=%b halt=%b",
						$time, instrValid, dataValid, halt);
					mismatchCount++;
				end
			end
			// First request must start at address zero
			if (instrValid && !fetchChecked) begin
				fetchChecked <= 1'b1;
				if (instrAddr !== 32'h0) begin
					$display("MISMATCH at %0t: first fetch at %h, expected 00000000",
						$time, instrAddr);
					mismatchCount++;
				end
			end
			if (dataValid && (halt || haltSeen)) begin
				$display("Data request to %h was issued after halt at %0t", dataAddr, $time);
				otherCount++;
			end
			if (halt) begin
				haltSeen <= 1'b1;
			end
			if (dataValid && dataReady && dataWrite) begin
				if (seenCount >= expCount) begin
					$display("Unexpected extra store of %h to %h at %0t", dataWdata, dataAddr, $time);
					otherCount++;
				end else if (dataAddr !== expAddr[seenCount] || dataWdata !== expData[seenCount]) begin
					$display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
						seenCount, dataWdata, dataAddr, expData[seenCount], expAddr[seenCount]);
					mismatchCount++;
				end
				seenCount++;
			end
		end
	end

endmodule

//--- cpuCore_tb.sv
// Memories hold 256 words each and wrap above byte address 0x3ff; stim layout is in cpu_stim.txt
`timescale 1ns/1ps

module cpuCore_tb;

	localparam int memWords = 256;
	localparam int stimWords = 768;
	localparam int delaySlots = 512;

	logic clk;
	logic rst;
	cpuIsaPkg::word_t instrAddr;
	logic instrValid;
	logic instrReady;
	cpuIsaPkg::word_t instrData;
	cpuIsaPkg::word_t dataAddr;
	logic dataWrite;
	cpuIsaPkg::word_t dataWdata;
	logic dataValid;
	logic dataReady;
	cpuIsaPkg::word_t dataRdata;
	logic halt;

	cpuIsaPkg::word_t stim [stimWords];
	cpuIsaPkg::word_t imem [memWords];
	cpuIsaPkg::word_t dmem [memWords];
	int delayTable [2 * delaySlots];
	logic instrBusy;
	logic dataBusy;
	int instrDelay;
	int dataDelay;
	int instrPick;
	int dataPick;
	int progLen;
	int dataPairs;
	int storeCount;
	int limit;
	int errors;
	int idx;

	cpuCore dut_i (.*);

	cpuChecker checkerInst (.*);

	bind cpuCore cpuCore_asserts coreAsserts (.*);

	always #2 clk = ~clk;

	// Instruction memory answers each request after 0 to 3 extra cycles
	always @(negedge clk) begin
		if (instrReady) begin
			instrReady = 1'b0;
			instrBusy = 1'b0;
		end
		if (!instrBusy && instrValid) begin
			instrBusy = 1'b1;
			instrDelay = delayTable[instrPick];
			instrPick = (instrPick + 1) % delaySlots;
		end
		if (instrBusy) begin
			if (instrDelay == 0) begin
				instrReady = 1'b1;
				instrData = imem[instrAddr[9:2]];
			end else begin
				instrDelay--;
			end
		end
	end

	// Data memory, same timing; a store lands when ready is raised
	always @(negedge clk) begin
		if (dataReady) begin
			dataReady = 1'b0;
			dataBusy = 1'b0;
		end
		if (!dataBusy && dataValid) begin
			dataBusy = 1'b1;
			dataDelay = delayTable[delaySlots + dataPick];
			dataPick = (dataPick + 1) % delaySlots;
		end
		if (dataBusy) begin
			if (dataDelay == 0) begin
				dataReady = 1'b1;
				dataRdata = dmem[dataAddr[9:2]];
				if (dataWrite) begin
					dmem[dataAddr[9:2]] = dataWdata;
				end
			end else begin
				dataDelay--;
			end
		end
	end

	initial begin
		void'($urandom(70));
		// Request latencies, first half for instructions and second half for data
		for (idx = 0; idx < 2 * delaySlots; idx++) begin
			delayTable[idx] = $urandom % 4;
		end
		instrPick = 0;
		dataPick = 0;
		clk = 1'b0;
		rst = 1'b1;
		instrReady = 1'b0;
		instrData = '0;
		dataReady = 1'b0;
		dataRdata = '0;
		instrBusy = 1'b0;
		dataBusy = 1'b0;
		$readmemh("cpu_stim.txt", stim);
		progLen = stim[0];
		dataPairs = stim[1];
		storeCount = stim[2];
		if (progLen == 0) begin
			$display("Could not read a program from cpu_stim.txt");
			$display("=== FAIL ===");
			$finish;
		end
		// Past the program the words are NOPs carrying their index
		for (idx = 0; idx < memWords; idx++) begin
			imem[idx] = (idx < progLen) ? stim[16 + idx] : cpuIsaPkg::word_t'(idx);
			dmem[idx] = 32'hd0d00000 | cpuIsaPkg::word_t'(idx);
		end
		for (idx = 0; idx < dataPairs; idx++) begin
			dmem[stim[256 + 2 * idx][9:2]] = stim[257 + 2 * idx];
		end
		for (idx = 0; idx < storeCount; idx++) begin
			checkerInst.addExpected(stim[512 + 2 * idx], stim[513 + 2 * idx]);
		end
		limit = progLen * 40 + 200;
		fork
			begin
				repeat (limit) @(posedge clk);
				$display("Timeout: halt did not rise within %0d cycles", limit);
				checkerInst.finishReport(errors);
				$display("=== FAIL ===");
				$finish;
			end
		join_none
		repeat (8) @(negedge clk);
		rst = 1'b0;
		while (!halt) @(negedge clk);
		// Idle time to catch a late data request
		repeat (20) @(negedge clk);
		checkerInst.finishReport(errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- cpu_stim.txt
// Words 0-2: program length, data pair count, expected store count
// @010 program words; @100 data (byte address, value); @200 expected stores (byte address, value)
@000
0000001C 00000002 00000005
@010
1C200005 // addi r1, r0, 5
1C410007 // addi r2, r1, 7
04611000 // add  r3, r1, r2
08830800 // sub  r4, r3, r1
14A41800 // xor  r5, r4, r3
24A00080 // sw   r5, 0x80(r0)
18C41800 // slt  r6, r4, r3
10E62000 // or   r7, r6, r4
24E00084 // sw   r7, 0x84(r0)
21000040 // lw   r8, 0x40(r0)
05280800 // add  r9, r8, r1
21400044 // lw   r10, 0x44(r0)
056A4800 // add  r11, r10, r9
25600088 // sw   r11, 0x88(r0)
28830002 // beq  r3, r4 not taken
2480008C // sw   r4, 0x8c(r0)
2C830002 // bne  r3, r4 taken to 0x4c
24200090 // sw   r1, 0x90(r0) skipped
24400094 // sw   r2, 0x94(r0) skipped
28820002 // beq  r2, r4 taken to 0x58
24200098 // sw   r1, 0x98(r0) skipped
2440009C // sw   r2, 0x9c(r0) skipped
30000002 // jmp  to 0x64
242000A0 // sw   r1, 0xa0(r0) skipped
244000A4 // sw   r2, 0xa4(r0) skipped
252000A8 // sw   r9, 0xa8(r0)
34000000 // halt
242000AC // sw   r1, 0xac(r0) never issued
@100
00000040 00000123
00000044 00000456
@200
00000080 0000001D
00000084 0000000D
00000088 0000057E
0000008C 0000000C
000000A8 00000128

//--- compile.f
cpuIsaPkg.sv
cpuPipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
cpuCore.sv
cpuCore_asserts.sv
cpuChecker.sv
cpuCore_tb.sv
